//--- rtl/pingpong_pkg.sv
/* Ping-pong sample buffer shared definitions
   Default sizes, swap state encoding and the bank control word */

package pingpong_pkg;

    // ====================
    // Default sizes
    // ====================
    localparam int unsigned DEF_WIDTH = 32;  // Bits per sample
    localparam int unsigned DEF_DEPTH = 16;  // Samples per buffer

    // ====================
    // Swap sequencing
    // ====================
    typedef enum logic [1:0] {
        FILLING      = 2'd0,  // First block still filling, nothing to read yet
        SWAP_PENDING = 2'd1,  // Write buffer full, roles change at next edge
        DRAINING     = 2'd2   // One buffer read out while the other fills
    } swap_state_e;

    // Control word from the swap FSM to both controllers and the bank
    typedef struct packed {
        logic swap;    // Swap executes at the coming edge
        logic wr_sel;  // Buffer taking writes
        logic rd_sel;  // Buffer being read out
    } bank_ctrl_t;

endpackage

//--- rtl/sample_ram.sv
/* Single-port sample RAM
   Synchronous write, combinational read of the addressed word */

`timescale 1ns/1ps

module sample_ram
    import pingpong_pkg::*;
#(
    parameter int unsigned WIDTH = DEF_WIDTH,  // Sample width
    parameter int unsigned DEPTH = DEF_DEPTH,  // Words in the array
    localparam int unsigned AW   = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic             clk_i,
    input  logic             we_i,     // Write strobe
    input  logic [AW-1:0]    addr_i,   // Shared read/write address
    input  logic [WIDTH-1:0] wdata_i,
    output logic [WIDTH-1:0] rdata_o   // Valid in the same cycle as addr_i
);

    logic [WIDTH-1:0] mem_q [DEPTH];  // Storage array

    // Write port
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem_q[addr_i] <= wdata_i;
        end
    end

    // Bypass-style read, no output register
    assign rdata_o = mem_q[addr_i];

endmodule

//--- rtl/buffer_bank.sv
/* Ping-pong buffer bank
   Two sample RAMs with write, address and read-data steering by the bank selects */

`timescale 1ns/1ps

module buffer_bank
    import pingpong_pkg::*;
#(
    parameter int unsigned WIDTH = DEF_WIDTH,
    parameter int unsigned DEPTH = DEF_DEPTH,
    localparam int unsigned AW   = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic             clk_i,
    input  bank_ctrl_t       ctrl_i,     // Buffer selects from the swap FSM
    input  logic             wr_en_i,    // Accepted write this cycle
    input  logic [AW-1:0]    wr_addr_i,
    input  logic [WIDTH-1:0] wr_data_i,
    input  logic [AW-1:0]    rd_addr_i,
    output logic [WIDTH-1:0] rd_data_o   // Word from the read buffer
);

    // ====================
    // Per-buffer signals
    // ====================
    logic             ram_we    [2];  // Write enable per buffer
    logic [AW-1:0]    ram_addr  [2];  // Address per buffer
    logic [WIDTH-1:0] ram_rdata [2];  // Read data per buffer

    for (genvar b = 0; b < 2; b++) begin : g_buf
        logic is_wr;  // This buffer is the write buffer

        assign is_wr = (ctrl_i.wr_sel == 1'(b));

        // Write side takes the address while selected, the reader gets it otherwise
        assign ram_we[b]   = wr_en_i && is_wr;
        assign ram_addr[b] = is_wr ? wr_addr_i : rd_addr_i;

        sample_ram #(
            .WIDTH (WIDTH),
            .DEPTH (DEPTH)
        ) sample_ram_i (
            .clk_i   (clk_i),
            .we_i    (ram_we[b]),
            .addr_i  (ram_addr[b]),
            .wdata_i (wr_data_i),      // Both buffers see the write data
            .rdata_o (ram_rdata[b])
        );
    end

    // ====================
    // Read data mux
    // ====================
    // Data is always driven, read valid qualifies it
    assign rd_data_o = ram_rdata[ctrl_i.rd_sel];

endmodule

//--- rtl/fill_ctrl.sv
/* Write side controller
   Write address, fill count, write ready and full detection */

`timescale 1ns/1ps

module fill_ctrl
    import pingpong_pkg::*;
#(
    parameter int unsigned DEPTH = DEF_DEPTH,
    localparam int unsigned AW   = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic          clk_i,
    input  logic          rst_ni,
    input  logic          valid_i,    // Writer offers a sample
    input  bank_ctrl_t    ctrl_i,     // Only the swap strobe matters here
    output logic          ready_o,    // Room left in the write buffer
    output logic          wr_en_o,    // Sample accepted this cycle
    output logic [AW-1:0] wr_addr_o,
    output logic [AW:0]   count_o,    // Samples in the write buffer
    output logic          full_o      // Count reached DEPTH
);

    logic [AW-1:0] addr_q;   // Next write location
    logic [AW:0]   count_q;  // One bit wider so DEPTH fits

    // ====================
    // Handshake
    // ====================
    assign ready_o = (count_q < (AW+1)'(DEPTH));   // Drops at the DEPTH-th accept
    assign full_o  = (count_q == (AW+1)'(DEPTH));
    assign wr_en_o = valid_i && ready_o;

    // Counters
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            addr_q  <= '0;
            count_q <= '0;
        end else if (ctrl_i.swap) begin
            // Fresh buffer after the swap
            addr_q  <= '0;
            count_q <= '0;
        end else if (wr_en_o) begin
            addr_q  <= addr_q + 1'b1;   // Wraps with the block
            count_q <= count_q + 1'b1;
        end
    end

    assign wr_addr_o = addr_q;
    assign count_o   = count_q;

endmodule

//--- rtl/swap_ctrl.sv
/* Buffer swap FSM
   Sequences the swap after a full block, owns the buffer selects and the ready pulse */

`timescale 1ns/1ps

module swap_ctrl
    import pingpong_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       full_i,          // Write buffer holds DEPTH samples
    output bank_ctrl_t ctrl_o,          // Selects and swap strobe
    output logic       buffer_ready_o   // One-cycle pulse after each swap
);

    swap_state_e state_q, state_d;
    logic        wr_sel_q;     // Buffer taking writes
    logic        rd_sel_q;     // Buffer being read
    logic        buf_rdy_q;    // Registered ready pulse
    logic        swap;         // Swap happens at the coming edge

    // ====================
    // Next state
    // ====================
    always_comb begin
        state_d = state_q;  // Hold by default
        case (state_q)
            FILLING, DRAINING: begin
                if (full_i) begin
                    state_d = SWAP_PENDING;  // Block complete
                end
            end
            SWAP_PENDING: state_d = DRAINING;  // Always one cycle only
            default:      state_d = FILLING;
        endcase
    end

    assign swap = (state_q == SWAP_PENDING);

    // ====================
    // State and selects
    // ====================
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q   <= FILLING;
            wr_sel_q  <= 1'b0;   // Buffer 0 fills first
            rd_sel_q  <= 1'b1;
            buf_rdy_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            buf_rdy_q <= swap;   // High only in the cycle after the swap edge
            if (swap) begin
                rd_sel_q <= wr_sel_q;   // Filled buffer becomes the read buffer
                wr_sel_q <= ~wr_sel_q;
            end
        end
    end

    assign ctrl_o.swap    = swap;
    assign ctrl_o.wr_sel  = wr_sel_q;
    assign ctrl_o.rd_sel  = rd_sel_q;
    assign buffer_ready_o = buf_rdy_q;

endmodule

//--- rtl/drain_ctrl.sv
/* Read side controller
   Read address, read position and read valid, closed off once a block is drained */

`timescale 1ns/1ps

module drain_ctrl
    import pingpong_pkg::*;
#(
    parameter int unsigned DEPTH = DEF_DEPTH,
    localparam int unsigned AW   = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic          clk_i,
    input  logic          rst_ni,
    input  logic          ready_i,    // Reader takes the sample
    input  bank_ctrl_t    ctrl_i,     // Swap strobe starts a new block
    output logic          valid_o,    // Read data offered
    output logic [AW-1:0] rd_addr_o,
    output logic [AW:0]   count_o     // Samples consumed from this block
);

    logic [AW-1:0] addr_q;     // Current read location
    logic [AW:0]   count_q;    // Reaches DEPTH when drained
    logic          loaded_q;   // A block has been handed over since reset
    logic          drained;    // All DEPTH samples consumed
    logic          rd_accept;  // Read handshake this cycle

    // ====================
    // Valid generation
    // ====================
    assign drained = (count_q == (AW+1)'(DEPTH));

    // Low in the swap cycle, so nothing is consumed from a block being abandoned
    assign valid_o   = loaded_q && !drained && !ctrl_i.swap;
    assign rd_accept = valid_o && ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            addr_q   <= '0;
            count_q  <= '0;
            loaded_q <= 1'b0;   // Nothing to read until the first swap
        end else if (ctrl_i.swap) begin
            // New block from position 0, unread rest of the old one is dropped
            addr_q   <= '0;
            count_q  <= '0;
            loaded_q <= 1'b1;
        end else if (rd_accept) begin
            addr_q  <= addr_q + 1'b1;
            count_q <= count_q + 1'b1;   // Stops at DEPTH, valid then holds low
        end
    end

    // Address and count hold under back-pressure
    assign rd_addr_o = addr_q;
    assign count_o   = count_q;

endmodule

//--- rtl/pingpong_buffer.sv
/* Ping-pong sample buffer top level
   Write side, swap FSM, read side and the two-buffer bank */

`timescale 1ns/1ps

module pingpong_buffer
    import pingpong_pkg::*;
#(
    parameter int unsigned WIDTH = DEF_WIDTH,  // Sample width
    parameter int unsigned DEPTH = DEF_DEPTH,  // Samples per block
    localparam int unsigned AW   = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic             clk_i,
    input  logic             rst_ni,          // Synchronous, active low

    // Write side
    input  logic [WIDTH-1:0] write_data_i,
    input  logic             write_valid_i,
    output logic             write_ready_o,

    // Read side
    output logic [WIDTH-1:0] read_data_o,     // Valid with read_valid_o
    output logic             read_valid_o,
    input  logic             read_ready_i,

    // Status
    output logic             buffer_ready_o,  // Pulse, new block readable
    output logic [AW:0]      write_count_o,   // Fill level of write buffer
    output logic [AW:0]      read_count_o     // Read position in read buffer
);

    // ====================
    // Internal wiring
    // ====================
    bank_ctrl_t    bank_ctrl;  // Selects and swap strobe
    logic          full;       // Write buffer complete
    logic          wr_en;      // Accepted write
    logic [AW-1:0] wr_addr;
    logic [AW-1:0] rd_addr;

    fill_ctrl #(
        .DEPTH (DEPTH)
    ) fill_ctrl_i (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .valid_i   (write_valid_i),
        .ctrl_i    (bank_ctrl),
        .ready_o   (write_ready_o),
        .wr_en_o   (wr_en),
        .wr_addr_o (wr_addr),
        .count_o   (write_count_o),
        .full_o    (full)
    );

    swap_ctrl swap_ctrl_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .full_i         (full),
        .ctrl_o         (bank_ctrl),
        .buffer_ready_o (buffer_ready_o)
    );

    drain_ctrl #(
        .DEPTH (DEPTH)
    ) drain_ctrl_i (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .ready_i   (read_ready_i),
        .ctrl_i    (bank_ctrl),
        .valid_o   (read_valid_o),
        .rd_addr_o (rd_addr),
        .count_o   (read_count_o)
    );

    // Storage, read data goes straight out
    buffer_bank #(
        .WIDTH (WIDTH),
        .DEPTH (DEPTH)
    ) buffer_bank_i (
        .clk_i     (clk_i),
        .ctrl_i    (bank_ctrl),
        .wr_en_i   (wr_en),
        .wr_addr_i (wr_addr),
        .wr_data_i (write_data_i),
        .rd_addr_i (rd_addr),
        .rd_data_o (read_data_o)
    );

endmodule

//--- bench/clk_rst_gen.sv
/* Testbench clock and reset source
   Free-running clock and a synchronous active-low reset held for a few cycles */

`timescale 1ns/1ps

module clk_rst_gen #(
    parameter int unsigned PERIOD_NS  = 20,  // Clock period
    parameter int unsigned RST_CYCLES = 4    // Rising edges with reset low
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Released right after the last reset edge
    initial begin
        rst_no = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_no <= 1'b1;
    end

endmodule

//--- bench/pingpong_monitor.sv
/* Ping-pong buffer monitor
   Cycle reference model of fill, swap and drain, compared with every DUT output */

`timescale 1ns/1ps

module pingpong_monitor
    import pingpong_pkg::*;
#(
    parameter int unsigned WIDTH = DEF_WIDTH,
    parameter int unsigned DEPTH = DEF_DEPTH,
    localparam int unsigned AW   = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic [WIDTH-1:0] write_data_i,
    input  logic             write_valid_i,
    input  logic             write_ready_i,
    input  logic [WIDTH-1:0] read_data_i,
    input  logic             read_valid_i,
    input  logic             read_ready_i,
    input  logic             buffer_ready_i,
    input  logic [AW:0]      write_count_i,
    input  logic [AW:0]      read_count_i,
    input  logic             end_run_i,      // Stimulus over or timed out
    input  logic             timed_out_i,
    output logic             report_done_o,  // Summary line printed
    output int unsigned      error_total_o
);

    logic [WIDTH-1:0] pending_q [$];        // Accepted samples of the block filling
    logic [WIDTH-1:0] read_q    [$];        // Rest of the block being read
    int unsigned      fill_cnt   = 0;
    int unsigned      rd_idx     = 0;
    int unsigned      full_age   = 0;       // Cycles seen with the block full
    logic             loaded     = 1'b0;    // A block was handed over
    logic             abandoned  = 1'b0;    // Last swap dropped unread samples
    logic             bready_exp = 1'b0;    // Pulse due this cycle
    logic             first_cyc  = 1'b1;    // Next cycle is the first out of reset
    logic             reported   = 1'b0;
    swap_state_e      cur_state  = FILLING; // Model state, shown in messages
    int unsigned      mismatch_cnt = 0;
    int unsigned      other_cnt    = 0;
    int unsigned      discard_cnt  = 0;     // First reads after a discard

    assign report_done_o = reported;
    assign error_total_o = mismatch_cnt + other_cnt;

    task automatic compare_value(input string test, input logic [WIDTH-1:0] exp_val,
                                 input logic [WIDTH-1:0] act_val);
        if (exp_val !== act_val) begin
            mismatch_cnt++;
            $display("MISMATCH %s: expected 0x%0h, actual 0x%0h (model state %s)",
                     test, exp_val, act_val, cur_state.name());
        end
    endtask

    // ====================
    // Model and checks
    // ====================
    always @(posedge clk_i) begin : model_check
        logic swap_cyc;
        logic exp_wready;
        logic exp_rvalid;
        if (!rst_ni) begin
            pending_q.delete();
            read_q.delete();
            fill_cnt   = 0;
            rd_idx     = 0;
            full_age   = 0;
            loaded     = 1'b0;
            abandoned  = 1'b0;
            bready_exp = 1'b0;
            first_cyc  = 1'b1;
            cur_state  = FILLING;
        end else begin
            swap_cyc   = (fill_cnt == DEPTH) && (full_age == 1);  // Second full cycle
            exp_wready = (fill_cnt < DEPTH);
            exp_rvalid = loaded && (rd_idx < DEPTH) && !swap_cyc;
            cur_state  = swap_cyc ? SWAP_PENDING : (loaded ? DRAINING : FILLING);

            if (first_cyc) begin
                compare_value("reset", WIDTH'(1'b1), WIDTH'(write_ready_i));
                compare_value("reset", WIDTH'(1'b0), WIDTH'(read_valid_i));
                compare_value("reset", WIDTH'(1'b0), WIDTH'(buffer_ready_i));
                first_cyc = 1'b0;
            end

            compare_value("fill_timing", WIDTH'(exp_wready), WIDTH'(write_ready_i));
            compare_value("buffer_ready", WIDTH'(bready_exp), WIDTH'(buffer_ready_i));
            compare_value("drain_limit", WIDTH'(exp_rvalid), WIDTH'(read_valid_i));
            compare_value("write_count", WIDTH'(fill_cnt), WIDTH'(write_count_i));
            compare_value("read_count", WIDTH'(rd_idx), WIDTH'(read_count_i));

            // Read side, model decides on acceptance
            if (exp_rvalid && read_ready_i) begin
                if (rd_idx == 0 && abandoned) begin
                    discard_cnt++;
                    compare_value("discard", read_q[0], read_data_i);
                end else begin
                    compare_value("data_order", read_q[0], read_data_i);
                end
                void'(read_q.pop_front());
                rd_idx++;
            end

            bready_exp = swap_cyc;
            if (swap_cyc) begin
                // Oldest completed block becomes the read block
                abandoned = loaded && (rd_idx < DEPTH);
                read_q.delete();
                repeat (DEPTH) read_q.push_back(pending_q.pop_front());
                fill_cnt  = 0;
                rd_idx    = 0;
                full_age  = 0;
                loaded    = 1'b1;
            end else begin
                if (fill_cnt == DEPTH) begin
                    full_age = 1;
                end
                if (write_valid_i && exp_wready) begin
                    pending_q.push_back(write_data_i);
                    fill_cnt++;
                end
            end
        end

        // Closing summary
        if (end_run_i && !reported) begin
            if (timed_out_i) begin
                other_cnt++;
            end
            if (discard_cnt == 0) begin
                $display("no read followed a swap that dropped unread samples");
                other_cnt++;
            end
            $display("Errors: %0d mismatches, %0d other failures, %0d total",
                     mismatch_cnt, other_cnt, mismatch_cnt + other_cnt);
            reported <= 1'b1;
        end
    end

endmodule

//--- bench/pingpong_tb.sv
/* Ping-pong buffer testbench top
   LCG driven writer and reader in three reader phases, with a run timeout */

`timescale 1ns/1ps

module pingpong_tb
    import pingpong_pkg::*;
();

    localparam int unsigned WIDTH = DEF_WIDTH;
    localparam int unsigned DEPTH = DEF_DEPTH;
    localparam int unsigned AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    localparam int unsigned FAST_BLOCKS  = 30;
    localparam int unsigned SLOW_BLOCKS  = 30;
    localparam int unsigned STALL_BLOCKS = 20;
    localparam int unsigned RUN_BLOCKS   = FAST_BLOCKS + SLOW_BLOCKS + STALL_BLOCKS;
    localparam int unsigned BLOCK_CYCLES = DEPTH * 4 / 3 + 4;  // Fill at 75% plus swap and slack
    localparam int unsigned CYCLE_LIMIT  = 2 * RUN_BLOCKS * BLOCK_CYCLES;  // Twice the run

    // Reader behaviour per phase
    localparam int READ_FAST  = 0;
    localparam int READ_SLOW  = 1;
    localparam int READ_STALL = 2;

    logic             clk;
    logic             rst_n;
    logic [WIDTH-1:0] write_data;
    logic             write_valid;
    logic             write_ready;
    logic [WIDTH-1:0] read_data;
    logic             read_valid;
    logic             read_ready;
    logic             buffer_ready;
    logic [AW:0]      write_count;
    logic [AW:0]      read_count;

    logic        stim_done;             // All phases completed
    logic        timed_out = 1'b0;      // Cycle limit reached
    logic        end_run;
    logic        report_done;           // Monitor printed its summary
    int unsigned error_total;
    int unsigned cycle_cnt = 0;
    logic [31:0] rng;                   // LCG state

    assign end_run = stim_done || timed_out;

    clk_rst_gen #(
        .PERIOD_NS  (20),
        .RST_CYCLES (4)
    ) clk_rst_gen_i (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    pingpong_buffer #(
        .WIDTH (WIDTH)
    ) pingpong_buffer_i (
        .clk_i          (clk),
        .rst_ni         (rst_n),
        .write_data_i   (write_data),
        .write_valid_i  (write_valid),
        .write_ready_o  (write_ready),
        .read_data_o    (read_data),
        .read_valid_o   (read_valid),
        .read_ready_i   (read_ready),
        .buffer_ready_o (buffer_ready),
        .write_count_o  (write_count),
        .read_count_o   (read_count)
    );

    pingpong_monitor #(
        .WIDTH (WIDTH),
        .DEPTH (DEPTH)
    ) pingpong_monitor_i (
        .clk_i          (clk),
        .rst_ni         (rst_n),
        .write_data_i   (write_data),
        .write_valid_i  (write_valid),
        .write_ready_i  (write_ready),
        .read_data_i    (read_data),
        .read_valid_i   (read_valid),
        .read_ready_i   (read_ready),
        .buffer_ready_i (buffer_ready),
        .write_count_i  (write_count),
        .read_count_i   (read_count),
        .end_run_i      (end_run),
        .timed_out_i    (timed_out),
        .report_done_o  (report_done),
        .error_total_o  (error_total)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;  // Widely used 32-bit LCG constants
    endfunction

    // Runs until the given number of blocks has been handed to the reader
    task automatic run_phase(input int unsigned blocks, input int read_mode);
        int unsigned swaps;
        swaps = 0;
        while (swaps < blocks) begin
            @(posedge clk);
            if (buffer_ready) begin
                swaps++;
            end
            // Offered sample stays put until the DUT takes it
            if (!(write_valid && !write_ready)) begin
                rng = lcg_step(rng);
                write_valid <= (rng[31:30] != 2'b00);  // About 75% offered
                rng = lcg_step(rng);
                write_data  <= WIDTH'(rng);
            end
            rng = lcg_step(rng);
            case (read_mode)
                READ_FAST: read_ready <= (rng[31:28] != 4'h0);  // Almost always
                READ_SLOW: read_ready <= (rng[31:30] == 2'b00); // About 25%
                default:   read_ready <= 1'b0;                  // Reader stalled
            endcase
        end
    endtask

    // ====================
    // Stimulus
    // ====================
    initial begin
        rng         = 32'h2aaa_dbd0;
        write_valid <= 1'b0;
        write_data  <= '0;
        read_ready  <= 1'b0;
        stim_done   <= 1'b0;
        wait (rst_n === 1'b1);
        run_phase(FAST_BLOCKS, READ_FAST);
        run_phase(SLOW_BLOCKS, READ_SLOW);   // Swaps overtake the reader
        run_phase(STALL_BLOCKS, READ_STALL);
        @(posedge clk);
        write_valid <= 1'b0;
        read_ready  <= 1'b0;
        stim_done   <= 1'b1;
    end

    // Cycle limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == CYCLE_LIMIT && !timed_out) begin
            $display("timeout: run did not complete");
            timed_out <= 1'b1;
        end
    end

    // Verdict once the monitor has printed the error counts
    initial begin
        wait (report_done === 1'b1);
        if (error_total == 0 && !timed_out) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- files.f
rtl/pingpong_pkg.sv
rtl/sample_ram.sv
rtl/buffer_bank.sv
rtl/fill_ctrl.sv
rtl/swap_ctrl.sv
rtl/drain_ctrl.sv
rtl/pingpong_buffer.sv
bench/clk_rst_gen.sv
bench/pingpong_monitor.sv
bench/pingpong_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the ping-pong buffer testbench with Verilator, verdict from the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module pingpong_tb -f files.f \
    && ./obj_dir/Vpingpong_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log

grep -q "Simulation finished: FAIL" sim.log && { echo "run failed"; exit 1; }
grep -q "Simulation finished" sim.log || { echo "run ended without a verdict"; exit 1; }
exit 0
